//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_bgpu
FILELIST  = project.f
PASS_MSG  = All tests passed!

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- common/bgpu_pkg.sv
/*
 * BGPU shared definitions
 * Sizes, register map, lane opcodes and JTAG instruction codes
 * used across the SIMT compute subsystem
 */
package bgpu_pkg;

    // ######################################
    // Sizes
    // ######################################

    // Compute lanes in one batch
    localparam int NUM_LANES = 4;
    // Operand and result width
    localparam int DATA_W = 16;
    // Host register address width
    localparam int ADDR_W = 8;
    // ACCESS register is {write flag, address, data}
    localparam int ACC_W = 1 + ADDR_W + DATA_W;
    // Reset stretch in system clock cycles
    localparam int RST_CYCLES = 4;

    // ######################################
    // JTAG
    // ######################################

    localparam int IR_W = 4;
    localparam logic [IR_W-1:0] IR_IDCODE = 4'h1;
    localparam logic [IR_W-1:0] IR_ACCESS = 4'h2;
    localparam logic [IR_W-1:0] IR_BYPASS = 4'hf;

    // Bit 0 must be set per IEEE 1149.1
    localparam logic [31:0] BGPU_IDCODE = 32'h1b90_c0d3;

    // ######################################
    // Register map
    // ######################################

    localparam logic [ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 8'h01;
    // Per-lane pages, base plus lane index
    localparam logic [ADDR_W-1:0] REG_A_BASE   = 8'h10;
    localparam logic [ADDR_W-1:0] REG_B_BASE   = 8'h20;
    localparam logic [ADDR_W-1:0] REG_OP_BASE  = 8'h30;
    localparam logic [ADDR_W-1:0] REG_RES_BASE = 8'h40;

    // Lane operations
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_XOR = 2'd3
    } lane_op_e;

endpackage : bgpu_pkg

//--- compute/compute_lane.sv
/*
 * Compute lane
 * One operation per start. Add, subtract and xor in one cycle,
 * multiply by shift-add over DATA_W cycles, low half kept
 */
module compute_lane
    import bgpu_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              start_i,
    input  logic [DATA_W-1:0] opa_i,
    input  logic [DATA_W-1:0] opb_i,
    input  lane_op_e          op_i,
    output logic              done_o,
    output logic [DATA_W-1:0] result_o
);

    // Multiplier state
    logic                        mul_run;
    logic [$clog2(DATA_W+1)-1:0] cnt;
    logic [DATA_W-1:0]           mcand, mplier;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            done_o  <= 1'b0;
            mul_run <= 1'b0;
            cnt     <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                case (op_i)
                    OP_ADD: result_o <= opa_i + opb_i;
                    OP_SUB: result_o <= opa_i - opb_i;
                    OP_XOR: result_o <= opa_i ^ opb_i;
                    default: begin
                        // Result doubles as the accumulator
                        result_o <= '0;
                        mcand    <= opa_i;
                        mplier   <= opb_i;
                        cnt      <= DATA_W[$clog2(DATA_W+1)-1:0];
                        mul_run  <= 1'b1;
                    end
                endcase
                done_o <= (op_i != OP_MUL);
            end else if (mul_run) begin
                // One multiplier bit per cycle
                if (mplier[0]) result_o <= result_o + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
                cnt    <= cnt - 1'b1;
                if (cnt == 1) begin
                    mul_run <= 1'b0;
                    done_o  <= 1'b1;
                end
            end
        end
    end

endmodule : compute_lane

//--- compute/lane_collector.sv
/*
 * Lane result collector
 * Captures each lane result on its done pulse and signals
 * the end of the batch once every lane has reported
 */
module lane_collector
    import bgpu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [NUM_LANES-1:0] lane_start_i,
    input  logic [NUM_LANES-1:0] lane_done_i,
    input  logic [DATA_W-1:0]    lane_result_i [NUM_LANES],
    output logic [DATA_W-1:0]    result_o [NUM_LANES],
    output logic                 batch_done_o
);

    logic [NUM_LANES-1:0] mask, mask_next;

    // Lanes reported so far, restarted by any start
    assign mask_next = (lane_start_i != '0) ? '0 : (mask | lane_done_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask         <= '0;
            batch_done_o <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) result_o[i] <= '0;
        end else begin
            mask <= mask_next;
            // Single pulse on the cycle the mask fills
            batch_done_o <= (&mask_next) && !(&mask);
            for (int i = 0; i < NUM_LANES; i++) begin
                if (lane_done_i[i]) result_o[i] <= lane_result_i[i];
            end
        end
    end

endmodule : lane_collector

//--- compute/lane_dispatcher.sv
/*
 * Lane dispatcher
 * Accepts a launch when idle, snapshots operands and
 * pulses every lane start. Busy until the batch completes
 */
module lane_dispatcher
    import bgpu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 launch_i,
    input  logic [DATA_W-1:0]    opa_i [NUM_LANES],
    input  logic [DATA_W-1:0]    opb_i [NUM_LANES],
    input  lane_op_e             opcode_i [NUM_LANES],
    input  logic                 batch_done_i,
    output logic                 busy_o,
    output logic [NUM_LANES-1:0] lane_start_o,
    output logic [DATA_W-1:0]    lane_opa_o [NUM_LANES],
    output logic [DATA_W-1:0]    lane_opb_o [NUM_LANES],
    output lane_op_e             lane_op_o [NUM_LANES]
);

    // Control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_o       <= 1'b0;
            lane_start_o <= '0;
        end else begin
            lane_start_o <= '0;
            if (launch_i && !busy_o) begin
                busy_o       <= 1'b1;
                lane_start_o <= '1;
            end else if (batch_done_i) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Operand snapshot, host may rewrite during a run
    always_ff @(posedge clk_i) begin
        if (launch_i && !busy_o) begin
            lane_opa_o <= opa_i;
            lane_opb_o <= opb_i;
            lane_op_o  <= opcode_i;
        end
    end

endmodule : lane_dispatcher

//--- dv/tb_jtag_tasks.svh
/*
 * JTAG host tasks
 * Bit-banged TAP reset, IR and DR scans, and host register
 * access through the ACCESS data register
 */
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

// One TCK period, 4 clocks low then 4 high
// TDO sampled at the end of the low phase, before the rising edge
task automatic tck_pulse(input logic tms_v, input logic tdi_v, output logic tdo_v);
    jtag_tms = tms_v;
    jtag_tdi = tdi_v;
    repeat (4) @(negedge clk);
    tdo_v    = jtag_tdo;
    jtag_tck = 1'b1;
    repeat (4) @(negedge clk);
    jtag_tck = 1'b0;
endtask

// Five TMS-high clocks reach Test-Logic-Reset, then park in Run-Test/Idle
task automatic tap_reset();
    logic unused;
    repeat (5) tck_pulse(1'b1, 1'b0, unused);
    tck_pulse(1'b0, 1'b0, unused);
endtask

// From Run-Test/Idle, LSB first, back to Run-Test/Idle
task automatic scan_ir(input logic [IR_W-1:0] code);
    logic unused;
    tck_pulse(1'b1, 1'b0, unused);
    tck_pulse(1'b1, 1'b0, unused);
    tck_pulse(1'b0, 1'b0, unused);
    // Capture-IR to Shift-IR
    tck_pulse(1'b0, 1'b0, unused);
    for (int i = 0; i < IR_W; i++) begin
        tck_pulse(i == IR_W - 1, code[i], unused);
    end
    tck_pulse(1'b1, 1'b0, unused);
    tck_pulse(1'b0, 1'b0, unused);
endtask

// Shifts len bits LSB first, returns what came out of TDO
task automatic scan_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
    logic bit_out;
    dout = '0;
    tck_pulse(1'b1, 1'b0, bit_out);
    tck_pulse(1'b0, 1'b0, bit_out);
    // Capture-DR to Shift-DR
    tck_pulse(1'b0, 1'b0, bit_out);
    for (int i = 0; i < len; i++) begin
        tck_pulse(i == len - 1, din[i], bit_out);
        dout[i] = bit_out;
    end
    // Exit1 to Update-DR, request issued here
    tck_pulse(1'b1, 1'b0, bit_out);
    tck_pulse(1'b0, 1'b0, bit_out);
endtask

// ACCESS word is {write flag, address, data}
task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [31:0] unused;
    scan_dr({{(32-ACC_W){1'b0}}, 1'b1, addr, data}, ACC_W, unused);
endtask

// First scan names the address, second one returns its data
task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic [31:0] dout;
    scan_dr({{(32-ACC_W){1'b0}}, 1'b0, addr, {DATA_W{1'b0}}}, ACC_W, dout);
    scan_dr({{(32-ACC_W){1'b0}}, 1'b0, addr, {DATA_W{1'b0}}}, ACC_W, dout);
    data = dout[DATA_W-1:0];
endtask

`endif

//--- dv/tb_bgpu.sv
/*
 * BGPU testbench
 * Drives the wrapper over JTAG. Checks IDCODE, BYPASS, register
 * readback, random lane batches against a model, and lock loss
 */
module tb_bgpu
    import bgpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BATCHES = 20;
    // About 50 TCK per scan, 8 clocks per TCK
    localparam int SCAN_CYCLES = 50 * 8;
    localparam int PLANNED_SCANS = 40 + 15 * NUM_LANES + NUM_BATCHES * (5 * NUM_LANES + 5);
    localparam int MAX_CYCLES = 2 * PLANNED_SCANS * SCAN_CYCLES;

    logic clk, reset, pll_locked;
    logic jtag_tck, jtag_tms, jtag_tdi, jtag_tdo;
    int   errors, checks, cycles;
    logic done_low_seen;

    // Model of the host-visible lane inputs
    logic [DATA_W-1:0] mdl_a [NUM_LANES];
    logic [DATA_W-1:0] mdl_b [NUM_LANES];
    lane_op_e          mdl_op [NUM_LANES];

    bgpu_wrapper uut (
        .clk_i       (clk),
        .reset_i     (reset),
        .pll_locked_i(pll_locked),
        .jtag_tck_i  (jtag_tck),
        .jtag_tms_i  (jtag_tms),
        .jtag_tdi_i  (jtag_tdi),
        .jtag_tdo_o  (jtag_tdo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Done bit is too quick to catch over JTAG after a launch
    always @(negedge clk) begin
        if (!uut.i_soc.i_regfile.done_q) done_low_seen = 1'b1;
    end

    `include "tb_jtag_tasks.svh"

    // ######################################
    // Model and compare tasks
    // ######################################

    // Opcode rule, modulo 2^DATA_W
    function automatic logic [DATA_W-1:0] lane_model(input lane_op_e op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
            input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ######################################
    // Tests
    // ######################################

    task automatic test_idcode();
        logic [31:0] word;
        tap_reset();
        // IR comes up as IDCODE, no IR scan needed
        scan_dr('0, 32, word);
        check_word("idcode", BGPU_IDCODE, word);
    endtask

    task automatic test_bypass();
        logic [31:0]       word;
        logic [DATA_W-1:0] pattern;
        pattern = DATA_W'($urandom);
        scan_ir(IR_BYPASS);
        // Extra clock flushes the last bit, capture bit leads
        scan_dr(32'(pattern), DATA_W + 1, word);
        check_word("bypass", 32'(pattern) << 1, word);
    endtask

    task automatic load_operands();
        for (int i = 0; i < NUM_LANES; i++) begin
            mdl_a[i]  = DATA_W'($urandom);
            mdl_b[i]  = DATA_W'($urandom);
            mdl_op[i] = lane_op_e'($urandom_range(3));
            reg_write(REG_A_BASE + ADDR_W'(i), mdl_a[i]);
            reg_write(REG_B_BASE + ADDR_W'(i), mdl_b[i]);
            reg_write(REG_OP_BASE + ADDR_W'(i), DATA_W'(mdl_op[i]));
        end
    endtask

    task automatic test_regs();
        logic [DATA_W-1:0] val;
        logic [ADDR_W-1:0] unmapped [5] = '{8'h02, 8'h14, 8'h3f, 8'h50, 8'hff};
        scan_ir(IR_ACCESS);
        load_operands();
        for (int i = 0; i < NUM_LANES; i++) begin
            reg_read(REG_A_BASE + ADDR_W'(i), val);
            check_data($sformatf("readback A lane %0d", i), mdl_a[i], val);
            reg_read(REG_B_BASE + ADDR_W'(i), val);
            check_data($sformatf("readback B lane %0d", i), mdl_b[i], val);
            reg_read(REG_OP_BASE + ADDR_W'(i), val);
            check_data($sformatf("readback OP lane %0d", i), DATA_W'(mdl_op[i]), val);
        end
        reg_read(REG_STATUS, val);
        check_bit("busy after reset", 1'b0, val[0]);
        check_bit("done after reset", 1'b0, val[1]);
        foreach (unmapped[i]) begin
            reg_read(unmapped[i], val);
            check_data($sformatf("unmapped %h", unmapped[i]), '0, val);
        end
    endtask

    // Poll STATUS until idle with done set
    task automatic wait_batch_done();
        logic [DATA_W-1:0] status;
        int                polls;
        polls = 0;
        do begin
            reg_read(REG_STATUS, status);
            polls++;
        end while ((status[0] || !status[1]) && polls < 8);
        if (status[0] || !status[1]) begin
            errors++;
            $display("Batch never completed: STATUS %h after %0d polls", status, polls);
        end
    endtask

    task automatic test_batches();
        logic [DATA_W-1:0] val;
        for (int n = 0; n < NUM_BATCHES; n++) begin
            load_operands();
            done_low_seen = 1'b0;
            reg_write(REG_CTRL, 16'h0001);
            wait_batch_done();
            // Previous batch left done set
            if (n > 0) check_bit($sformatf("batch %0d launch clears done", n), 1'b1, done_low_seen);
            for (int i = 0; i < NUM_LANES; i++) begin
                reg_read(REG_RES_BASE + ADDR_W'(i), val);
                check_data($sformatf("batch %0d lane %0d", n, i),
                           lane_model(mdl_op[i], mdl_a[i], mdl_b[i]), val);
            end
        end
    endtask

    task automatic test_lock_loss();
        logic [31:0]       word;
        logic [DATA_W-1:0] val;
        pll_locked = 1'b0;
        repeat (3) @(negedge clk);
        pll_locked = 1'b1;
        repeat (2 * RST_CYCLES) @(negedge clk);
        tap_reset();
        scan_dr('0, 32, word);
        check_word("idcode after lock loss", BGPU_IDCODE, word);
        scan_ir(IR_ACCESS);
        reg_read(REG_STATUS, val);
        check_data("status after lock loss", '0, val);
        for (int i = 0; i < NUM_LANES; i++) begin
            reg_read(REG_A_BASE + ADDR_W'(i), val);
            check_data($sformatf("A lane %0d after lock loss", i), '0, val);
            reg_read(REG_B_BASE + ADDR_W'(i), val);
            check_data($sformatf("B lane %0d after lock loss", i), '0, val);
            reg_read(REG_OP_BASE + ADDR_W'(i), val);
            check_data($sformatf("OP lane %0d after lock loss", i), '0, val);
            reg_read(REG_RES_BASE + ADDR_W'(i), val);
            check_data($sformatf("result lane %0d after lock loss", i), '0, val);
        end
    endtask

    // ######################################
    // Main sequence
    // ######################################

    initial begin
        void'($urandom(32'hf2aa_3f78));
        reset         = 1'b1;
        pll_locked    = 1'b1;
        jtag_tck      = 1'b0;
        jtag_tms      = 1'b1;
        jtag_tdi      = 1'b0;
        done_low_seen = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // Let the stretched reset release
        repeat (2 * RST_CYCLES) @(negedge clk);

        test_idcode();
        test_bypass();
        test_regs();
        test_batches();
        test_lock_loss();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_bgpu

//--- jtag/jtag_tap.sv
/*
 * JTAG test access port
 * TCK, TMS and TDI are oversampled on the system clock. Runs the
 * 16-state TAP controller with IDCODE, BYPASS and ACCESS data
 * registers. ACCESS turns Update-DR into a host register request
 */
module jtag_tap
    import bgpu_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              jtag_tck_i,
    input  logic              jtag_tms_i,
    input  logic              jtag_tdi_i,
    output logic              jtag_tdo_o,
    output logic              reg_req_o,
    output logic              reg_we_o,
    output logic [ADDR_W-1:0] reg_addr_o,
    output logic [DATA_W-1:0] reg_wdata_o,
    input  logic [DATA_W-1:0] reg_rdata_i
);

    typedef enum logic [3:0] {
        TLR, RTI, SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPD_DR,
        SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPD_IR
    } tap_state_e;

    tap_state_e state, state_next;

    // ######################################
    // Pin oversampling
    // ######################################

    // Two sync stages, third TCK stage for edge detect
    logic [2:0] tck_q;
    logic [1:0] tms_q, tdi_q;
    logic tck_rise, tck_fall, tms, tdi;

    always_ff @(posedge clk_i) begin
        tck_q <= {tck_q[1:0], jtag_tck_i};
        tms_q <= {tms_q[0], jtag_tms_i};
        tdi_q <= {tdi_q[0], jtag_tdi_i};
    end

    assign tck_rise = tck_q[1] && !tck_q[2];
    assign tck_fall = !tck_q[1] && tck_q[2];
    assign tms      = tms_q[1];
    assign tdi      = tdi_q[1];

    // ######################################
    // TAP controller
    // ######################################

    always_comb begin
        case (state)
            TLR:      state_next = tms ? TLR      : RTI;
            RTI:      state_next = tms ? SEL_DR   : RTI;
            SEL_DR:   state_next = tms ? SEL_IR   : CAP_DR;
            CAP_DR:   state_next = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR: state_next = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR: state_next = tms ? UPD_DR   : PAUSE_DR;
            PAUSE_DR: state_next = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR: state_next = tms ? UPD_DR   : SHIFT_DR;
            UPD_DR:   state_next = tms ? SEL_DR   : RTI;
            SEL_IR:   state_next = tms ? TLR      : CAP_IR;
            CAP_IR:   state_next = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR: state_next = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR: state_next = tms ? UPD_IR   : PAUSE_IR;
            PAUSE_IR: state_next = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR: state_next = tms ? UPD_IR   : SHIFT_IR;
            default:  state_next = tms ? SEL_DR   : RTI;
        endcase
    end

    // ######################################
    // Instruction and data registers
    // ######################################

    logic [IR_W-1:0]   ir, ir_shift;
    // Shared DR shifter, widest register is IDCODE
    logic [31:0]       dr;
    logic              req_q;
    logic [DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state      <= TLR;
            ir         <= IR_IDCODE;
            jtag_tdo_o <= 1'b0;
            reg_req_o  <= 1'b0;
            req_q      <= 1'b0;
            rdata_q    <= '0;
        end else begin
            reg_req_o <= 1'b0;
            req_q     <= reg_req_o;
            // Register file answers one cycle after the request
            if (req_q) rdata_q <= reg_rdata_i;

            if (tck_rise) begin
                state <= state_next;
                case (state)
                    TLR:      ir <= IR_IDCODE;
                    CAP_IR:   ir_shift <= IR_W'(1);
                    SHIFT_IR: ir_shift <= {tdi, ir_shift[IR_W-1:1]};
                    UPD_IR:   ir <= ir_shift;
                    CAP_DR: begin
                        case (ir)
                            IR_IDCODE: dr <= BGPU_IDCODE;
                            // Data field carries the last read value
                            IR_ACCESS: dr <= {{(32-DATA_W){1'b0}}, rdata_q};
                            default:   dr <= '0;
                        endcase
                    end
                    SHIFT_DR: begin
                        // Insert TDI at the top of the selected length
                        case (ir)
                            IR_IDCODE: dr <= {tdi, dr[31:1]};
                            IR_ACCESS: dr[ACC_W-1:0] <= {tdi, dr[ACC_W-1:1]};
                            default:   dr[0] <= tdi;
                        endcase
                    end
                    UPD_DR: begin
                        if (ir == IR_ACCESS) begin
                            reg_req_o   <= 1'b1;
                            reg_we_o    <= dr[ACC_W-1];
                            reg_addr_o  <= dr[DATA_W +: ADDR_W];
                            reg_wdata_o <= dr[DATA_W-1:0];
                        end
                    end
                    default: ;
                endcase
            end

            // TDO follows the falling edge
            if (tck_fall) begin
                if (state == SHIFT_IR) begin
                    jtag_tdo_o <= ir_shift[0];
                end else if (state == SHIFT_DR) begin
                    jtag_tdo_o <= dr[0];
                end else begin
                    jtag_tdo_o <= 1'b0;
                end
            end
        end
    end

endmodule : jtag_tap

//--- project.f
+incdir+dv
common/bgpu_pkg.sv
rtl/rst_sync.sv
jtag/jtag_tap.sv
rtl/bgpu_regfile.sv
compute/lane_dispatcher.sv
compute/compute_lane.sv
compute/lane_collector.sv
rtl/bgpu_soc.sv
rtl/bgpu_wrapper.sv
dv/tb_bgpu.sv

//--- rtl/bgpu_regfile.sv
/*
 * Host register file
 * Decodes register requests from the TAP, holds per-lane
 * operands and opcodes, status and the launch strobe
 */
module bgpu_regfile
    import bgpu_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              reg_req_i,
    input  logic              reg_we_i,
    input  logic [ADDR_W-1:0] reg_addr_i,
    input  logic [DATA_W-1:0] reg_wdata_i,
    output logic [DATA_W-1:0] reg_rdata_o,
    input  logic              busy_i,
    input  logic              batch_done_i,
    input  logic [DATA_W-1:0] lane_result_i [NUM_LANES],
    output logic              launch_o,
    output logic [DATA_W-1:0] opa_o [NUM_LANES],
    output logic [DATA_W-1:0] opb_o [NUM_LANES],
    output lane_op_e          opcode_o [NUM_LANES]
);

    // Page in the upper nibble, lane in the lower one
    logic [ADDR_W-5:0]            page;
    logic [$clog2(NUM_LANES)-1:0] lane_idx;
    logic                         lane_hit;
    logic                         done_q;
    logic [DATA_W-1:0]            rdata_next;

    assign page     = reg_addr_i[ADDR_W-1:4];
    assign lane_idx = reg_addr_i[$clog2(NUM_LANES)-1:0];
    assign lane_hit = reg_addr_i[3:0] < NUM_LANES;

    // Read mux, unmapped reads return zero
    always_comb begin
        rdata_next = '0;
        if (reg_addr_i == REG_STATUS) begin
            rdata_next = {{(DATA_W-2){1'b0}}, done_q, busy_i};
        end else if (lane_hit) begin
            case (page)
                REG_A_BASE[ADDR_W-1:4]:   rdata_next = opa_o[lane_idx];
                REG_B_BASE[ADDR_W-1:4]:   rdata_next = opb_o[lane_idx];
                REG_OP_BASE[ADDR_W-1:4]:  rdata_next = DATA_W'(opcode_o[lane_idx]);
                REG_RES_BASE[ADDR_W-1:4]: rdata_next = lane_result_i[lane_idx];
                default:                  rdata_next = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            launch_o    <= 1'b0;
            done_q      <= 1'b0;
            reg_rdata_o <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                opa_o[i]    <= '0;
                opb_o[i]    <= '0;
                opcode_o[i] <= OP_ADD;
            end
        end else begin
            launch_o <= 1'b0;
            // Sticky done, cleared by an accepted launch
            if (batch_done_i) done_q <= 1'b1;
            if (launch_o && !busy_i) done_q <= 1'b0;

            if (reg_req_i) reg_rdata_o <= rdata_next;

            if (reg_req_i && reg_we_i) begin
                if (reg_addr_i == REG_CTRL && reg_wdata_i[0]) launch_o <= 1'b1;
                if (lane_hit) begin
                    case (page)
                        REG_A_BASE[ADDR_W-1:4]:  opa_o[lane_idx] <= reg_wdata_i;
                        REG_B_BASE[ADDR_W-1:4]:  opb_o[lane_idx] <= reg_wdata_i;
                        REG_OP_BASE[ADDR_W-1:4]: opcode_o[lane_idx] <= lane_op_e'(reg_wdata_i[1:0]);
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule : bgpu_regfile

//--- rtl/bgpu_soc.sv
/*
 * BGPU SoC
 * JTAG TAP for host access, register file, dispatcher,
 * compute lanes and result collector
 */
module bgpu_soc
    import bgpu_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic jtag_tck_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic jtag_tdo_o
);

    // ######################################
    // Signals
    // ######################################

    // Host register bus
    logic              reg_req, reg_we;
    logic [ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0] reg_wdata, reg_rdata;

    // Batch control
    logic launch, busy, batch_done;

    // Host-side and snapshotted lane inputs
    logic [DATA_W-1:0] opa [NUM_LANES], opb [NUM_LANES];
    lane_op_e          opcode [NUM_LANES];
    logic [DATA_W-1:0] lane_opa [NUM_LANES], lane_opb [NUM_LANES];
    lane_op_e          lane_op [NUM_LANES];

    // Lane outputs and collected results
    logic [NUM_LANES-1:0] lane_start, lane_done;
    logic [DATA_W-1:0]    lane_result [NUM_LANES], result [NUM_LANES];

    // ######################################
    // Host access
    // ######################################

    jtag_tap i_tap (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .jtag_tck_i (jtag_tck_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .jtag_tdo_o (jtag_tdo_o),
        .reg_req_o  (reg_req),
        .reg_we_o   (reg_we),
        .reg_addr_o (reg_addr),
        .reg_wdata_o(reg_wdata),
        .reg_rdata_i(reg_rdata)
    );

    bgpu_regfile i_regfile (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .reg_req_i    (reg_req),
        .reg_we_i     (reg_we),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .busy_i       (busy),
        .batch_done_i (batch_done),
        .lane_result_i(result),
        .launch_o     (launch),
        .opa_o        (opa),
        .opb_o        (opb),
        .opcode_o     (opcode)
    );

    // ######################################
    // Compute
    // ######################################

    lane_dispatcher i_dispatcher (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .launch_i    (launch),
        .opa_i       (opa),
        .opb_i       (opb),
        .opcode_i    (opcode),
        .batch_done_i(batch_done),
        .busy_o      (busy),
        .lane_start_o(lane_start),
        .lane_opa_o  (lane_opa),
        .lane_opb_o  (lane_opb),
        .lane_op_o   (lane_op)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        compute_lane i_lane (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .start_i (lane_start[i]),
            .opa_i   (lane_opa[i]),
            .opb_i   (lane_opb[i]),
            .op_i    (lane_op[i]),
            .done_o  (lane_done[i]),
            .result_o(lane_result[i])
        );
    end

    lane_collector i_collector (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lane_start_i (lane_start),
        .lane_done_i  (lane_done),
        .lane_result_i(lane_result),
        .result_o     (result),
        .batch_done_o (batch_done)
    );

endmodule : bgpu_soc

//--- rtl/bgpu_wrapper.sv
/*
 * BGPU FPGA top level
 * Board clock used directly, system reset stretched from
 * the reset pin and clock generator lock, then the SoC
 */
module bgpu_wrapper (
    input  logic clk_i,
    input  logic reset_i,
    input  logic pll_locked_i,
    input  logic jtag_tck_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic jtag_tdo_o
);

    // Stretched system reset
    logic rst_sys;

    rst_sync i_rst_sync (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pll_locked_i(pll_locked_i),
        .rst_sys_o   (rst_sys)
    );

    bgpu_soc i_soc (
        .clk_i     (clk_i),
        .reset_i   (rst_sys),
        .jtag_tck_i(jtag_tck_i),
        .jtag_tms_i(jtag_tms_i),
        .jtag_tdi_i(jtag_tdi_i),
        .jtag_tdo_o(jtag_tdo_o)
    );

endmodule : bgpu_wrapper

//--- rtl/rst_sync.sv
/*
 * Reset stretcher
 * Holds the system reset while reset_i is high or the clock
 * generator is unlocked, then for RST_CYCLES more cycles
 */
module rst_sync
    import bgpu_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic pll_locked_i,
    output logic rst_sys_o
);

    // Any reset request
    logic req;
    // Remaining stretch cycles
    logic [$clog2(RST_CYCLES+1)-1:0] cnt;

    assign req = reset_i || !pll_locked_i;

    // Reload on request, count down once released
    always_ff @(posedge clk_i) begin
        if (req) begin
            cnt <= RST_CYCLES[$clog2(RST_CYCLES+1)-1:0];
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Immediate assertion, delayed release
    assign rst_sys_o = req || (cnt != '0);

endmodule : rst_sync
